/* build.f */
rtl/gac_pkg.sv
rtl/sync_fifo.sv
rtl/action_table.sv
rtl/cfg_slave.sv
rtl/action_engine.sv
rtl/gac_top.sv
sim/tb_gac.sv

/* Makefile */
# Verilator build and run for the action stage testbench

VERILATOR ?= verilator
TOP       ?= tb_gac
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= All tests passed!

SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sim/tb_gac.sv */
// testbench for the action stage
// bus and packet tasks, output monitor, expected-word queue and directed tests
`timescale 1ns/1ps

module tb_gac import gac_pkg::*; ();

	logic        clk;
	logic        rst_n;
	logic [5:0]  sys_max_cpuid;
	pkt_word_t   in_data;
	logic        in_data_wr;
	logic        in_data_alf;
	md_t         in_md;
	logic        in_md_wr;
	logic        in_md_alf;
	pkt_word_t   out_data;
	logic        out_data_wr;
	logic        out_alf;
	logic        cfg_req;
	cfg_req_t    cfg;
	logic        cfg_ack;
	logic [31:0] cfg_rdata;

	pkt_word_t   tx_words [0:7];
	int          tx_len;
	pkt_word_t   out_q[$];       // words seen on the output
	pkt_word_t   expect_q[$];    // words the rules predict
	logic [7:0]  flow_of [0:4];
	action_t     act_of [0:4];
	int          n_sent;
	int          n_out;

	gac_top u_gac_top (
		.clk           (clk),
		.rst_n         (rst_n),
		.sys_max_cpuid (sys_max_cpuid),
		.in_data       (in_data),
		.in_data_wr    (in_data_wr),
		.in_data_alf   (in_data_alf),
		.in_md         (in_md),
		.in_md_wr      (in_md_wr),
		.in_md_alf     (in_md_alf),
		.out_data      (out_data),
		.out_data_wr   (out_data_wr),
		.out_alf       (out_alf),
		.cfg_req       (cfg_req),
		.cfg           (cfg),
		.cfg_ack       (cfg_ack),
		.cfg_rdata     (cfg_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// sampled mid-cycle, away from the active edge
	always @(negedge clk) begin
		if (rst_n && out_data_wr)
			out_q.push_back(out_data);
	end

	// ********************
	// checks
	// ********************
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_eq(input string name, input logic [133:0] got, input logic [133:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
	endtask

	// ********************
	// register bus
	// ********************
	task automatic bus_access(input logic rw, input logic [15:0] addr, input logic [31:0] data,
	                          output logic [31:0] rdata);
		int t;
		@(posedge clk);
		cfg.rw    <= rw;
		cfg.addr  <= addr;
		cfg.wdata <= data;
		cfg_req   <= 1'b1;
		t = 0;
		while (!cfg_ack) begin
			@(posedge clk);
			t++;
			if (t > 50)
				abort_run("bus ack never rose after the request");
		end
		rdata   = cfg_rdata;    // valid together with ack
		cfg_req <= 1'b0;
		t = 0;
		while (cfg_ack) begin
			@(posedge clk);
			t++;
			if (t > 50)
				abort_run("bus ack never fell after the request was dropped");
		end
	endtask

	task automatic bus_write(input logic [15:0] addr, input logic [31:0] data);
		logic [31:0] unused;
		bus_access(1'b0, addr, data, unused);
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [31:0] data);
		bus_access(1'b1, addr, 32'h0, data);
	endtask

	// ********************
	// packet helpers
	// ********************
	function automatic md_t rand_md(input logic [7:0] dmid, input logic [7:0] flow);
		md_t md;
		md = {$urandom, $urandom, $urandom, $urandom};
		md.dmid = dmid;
		md[flow_idx_msb:flow_idx_lsb] = flow;
		return md;
	endfunction

	// expected metadata after an action, per the rewrite table
	function automatic md_t rewrite_md(input md_t md, input action_t a, input logic [5:0] port);
		md_t r;
		r = md;
		if (a.code == act_set_dmid) begin
			r.pktdes  = 1'b1;
			r.outtype = 2'd0;
			r.dmid    = a.dmid;
		end else begin
			r.dmid    = next_mid;
			r.pktdes  = (a.code != act_to_port);
			r.outtype = (a.code == act_cpu_fixed) ? 2'd1 : (a.code == act_cpu_poll) ? 2'd2 : 2'd0;
			r.outport = (a.code == act_cpu_poll) ? port : a.dmid[5:0];
		end
		return r;
	endfunction

	task automatic make_words(input int len);
		int i;
		tx_len = len;
		for (i = 0; i < len; i++) begin
			tx_words[i].hdr  = 4'($urandom);
			tx_words[i].body = {$urandom, $urandom, $urandom, $urandom};
			if (i == len - 1)
				tx_words[i].tag = tag_tail;
			else if (i == 0)
				tx_words[i].tag = 2'd1;    // head
			else
				tx_words[i].tag = 2'd3;    // body
		end
	endtask

	task automatic send_packet(input md_t md);
		int i;
		int t;
		t = 0;
		while (in_data_alf || in_md_alf) begin
			@(posedge clk);
			t++;
			if (t > 1000)
				abort_run("input almost-full flags stayed high");
		end
		@(posedge clk);
		in_md    <= md;
		in_md_wr <= 1'b1;
		for (i = 0; i < tx_len; i++) begin
			@(posedge clk);
			in_md_wr   <= 1'b0;
			in_data    <= tx_words[i];
			in_data_wr <= 1'b1;
		end
		@(posedge clk);
		in_data_wr <= 1'b0;
		n_sent++;
	endtask

	task automatic push_expected(input logic [md_w-1:0] first_body);
		int        i;
		pkt_word_t w;
		for (i = 0; i < tx_len; i++) begin
			w = tx_words[i];
			if (i == 0)
				w.body = first_body;
			expect_q.push_back(w);
		end
		n_out++;
	endtask

	task automatic recv_packet();
		pkt_word_t got;
		pkt_word_t exp;
		int        t;
		bit        done;
		done = 1'b0;
		while (!done) begin
			t = 0;
			while (out_q.size() == 0) begin
				@(posedge clk);
				t++;
				if (t > 500)
					abort_run("no output word arrived before the timeout");
			end
			got = out_q.pop_front();
			if (expect_q.size() == 0)
				abort_run("an output word arrived while no packet was expected");
			exp = expect_q.pop_front();
			check_eq("out_data", got, exp);
			done = (got.tag == tag_tail);
		end
	endtask

	// ********************
	// directed tests
	// ********************
	task automatic table_access();
		logic [31:0] rd;
		int          i;
		flow_of[0] = 8'h10;
		act_of[0]  = 32'h10a5c32b;    // cpu fixed, outport 0x2b
		flow_of[1] = 8'h21;
		act_of[1]  = 32'h300f0017;    // to port 0x17
		flow_of[2] = 8'h32;
		act_of[2]  = 32'h21234500;    // cpu poll
		flow_of[3] = 8'h43;
		act_of[3]  = 32'h40000077;    // set dmid 0x77
		flow_of[4] = 8'hfe;
		act_of[4]  = 32'hf000013c;    // unknown code, discard
		for (i = 0; i < 5; i++)
			bus_write({5'd0, 1'b0, flow_of[i], 2'b00}, act_of[i]);
		bus_write({5'd0, 1'b0, 8'h00, 2'b00}, 32'h5a5a0001);
		bus_write({5'd0, 1'b0, 8'hff, 2'b00}, 32'ha5a5ffff);
		for (i = 0; i < 5; i++) begin
			bus_read({5'd0, 1'b0, flow_of[i], 2'b00}, rd);
			check_eq("cfg_rdata", rd, act_of[i]);
		end
		bus_read({5'd0, 1'b0, 8'h00, 2'b00}, rd);
		check_eq("cfg_rdata", rd, 32'h5a5a0001);
		bus_read({5'd0, 1'b0, 8'hff, 2'b00}, rd);
		check_eq("cfg_rdata", rd, 32'ha5a5ffff);
		// statistics space takes no writes
		bus_write({5'd0, 1'b1, flow_of[0], 2'b00}, 32'hdeadbeef);
		bus_read({5'd0, 1'b0, flow_of[0], 2'b00}, rd);
		check_eq("cfg_rdata", rd, act_of[0]);    // table entry untouched
		bus_write({5'd0, 1'b1, stat_in_pkt_idx, 2'b00}, 32'hdeadbeef);
		bus_read({5'd0, 1'b1, stat_in_pkt_idx, 2'b00}, rd);
		check_eq("stat_in_pkt", rd, 32'h0);
	endtask

	task automatic passthrough_pkts();
		md_t        md;
		logic [7:0] dmid;
		int         k;
		for (k = 0; k < 3; k++) begin
			dmid = 8'($urandom);
			if (dmid == local_mid)
				dmid = 8'h07;
			md = rand_md(dmid, 8'($urandom));
			make_words(2 + int'($urandom % 5));
			send_packet(md);
			push_expected(tx_words[0].body);
		end
		for (k = 0; k < 3; k++)
			recv_packet();
	endtask

	task automatic fixed_rewrites();
		md_t md;
		int  k;
		for (k = 0; k < 2; k++) begin
			md = rand_md(local_mid, flow_of[k]);
			make_words(2 + int'($urandom % 5));
			send_packet(md);
			push_expected(rewrite_md(md, act_of[k], 6'd0));
		end
		recv_packet();
		recv_packet();
	endtask

	task automatic cpu_polling();
		md_t md;
		int  k;
		for (k = 0; k < 4; k++) begin
			md = rand_md(local_mid, flow_of[2]);
			make_words(2 + int'($urandom % 5));
			send_packet(md);
			push_expected(rewrite_md(md, act_of[2], 6'(k % 3)));    // max cpu id 3
		end
		for (k = 0; k < 4; k++)
			recv_packet();
	endtask

	task automatic dmid_and_discard();
		md_t md;
		md = rand_md(local_mid, flow_of[3]);
		make_words(2 + int'($urandom % 5));
		send_packet(md);
		push_expected(rewrite_md(md, act_of[3], 6'd0));
		md = rand_md(local_mid, flow_of[4]);
		make_words(2 + int'($urandom % 5));
		send_packet(md);    // dropped, nothing expected
		md = rand_md(8'h09, 8'($urandom));
		make_words(2 + int'($urandom % 5));
		send_packet(md);
		push_expected(tx_words[0].body);
		recv_packet();
		recv_packet();
		repeat (20) @(posedge clk);
		check_eq("out_q_size", out_q.size(), 0);
	endtask

	// fill both input fifos up to their alf levels while downstream is full
	task automatic back_pressure();
		md_t md;
		int  k;
		out_alf <= 1'b1;
		for (k = 0; k < md_alf_level; k++) begin
			if (k == md_alf_level - 1) begin
				check_eq("in_data_alf", in_data_alf, 1'b0);
				check_eq("in_md_alf", in_md_alf, 1'b0);
			end
			md = rand_md(8'h09, 8'($urandom));
			make_words(data_alf_level / md_alf_level);
			send_packet(md);
			push_expected(tx_words[0].body);
		end
		@(posedge clk);    // last word lands in the fifo
		check_eq("in_data_alf", in_data_alf, 1'b1);
		check_eq("in_md_alf", in_md_alf, 1'b1);
		check_eq("out_q_size", out_q.size(), 0);    // no start while out_alf is high
		out_alf <= 1'b0;
		for (k = 0; k < md_alf_level; k++)
			recv_packet();
		check_eq("in_data_alf", in_data_alf, 1'b0);
		check_eq("in_md_alf", in_md_alf, 1'b0);
	endtask

	task automatic stats_counters();
		logic [31:0] rd;
		bus_read({5'd0, 1'b1, stat_in_pkt_idx, 2'b00}, rd);
		check_eq("stat_in_pkt", rd, n_sent);
		bus_read({5'd0, 1'b1, stat_md_idx, 2'b00}, rd);
		check_eq("stat_md", rd, n_sent);    // one record per packet
		bus_read({5'd0, 1'b1, stat_out_pkt_idx, 2'b00}, rd);
		check_eq("stat_out_pkt", rd, n_out);
		bus_read({5'd0, 1'b1, 8'd4, 2'b00}, rd);
		check_eq("stat_unused", rd, 32'h0);
	endtask

	initial begin
		void'($urandom(8));
		rst_n         = 1'b0;
		sys_max_cpuid = 6'd3;
		in_data       = '0;
		in_data_wr    = 1'b0;
		in_md         = '0;
		in_md_wr      = 1'b0;
		out_alf       = 1'b0;
		cfg_req       = 1'b0;
		cfg           = '0;
		n_sent        = 0;
		n_out         = 0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		repeat (2) @(posedge clk);
		table_access();
		passthrough_pkts();
		fixed_rewrites();
		cpu_polling();
		dmid_and_discard();
		back_pressure();
		stats_counters();
		$display("All tests passed!");
		$finish;
	end

endmodule

/* rtl/gac_top.sv */
// action stage top level
// input fifos, almost-full flags, action table, bus slave and engine
`timescale 1ns/1ps

module gac_top import gac_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic [5:0]  sys_max_cpuid,
	input  pkt_word_t   in_data,
	input  logic        in_data_wr,
	output logic        in_data_alf,
	input  md_t         in_md,
	input  logic        in_md_wr,
	output logic        in_md_alf,
	output pkt_word_t   out_data,
	output logic        out_data_wr,
	input  logic        out_alf,
	input  logic        cfg_req,
	input  cfg_req_t    cfg,
	output logic        cfg_ack,
	output logic [31:0] cfg_rdata
);
	pkt_word_t                         data_head;
	logic                              data_empty;
	logic                              data_pop;
	logic [$clog2(data_fifo_depth):0]  data_count;
	md_t                               md_head;
	logic                              md_empty;
	logic                              md_pop;
	logic [$clog2(md_fifo_depth):0]    md_count;

	logic [table_aw-1:0] tbl_addr;
	action_t             tbl_wdata;
	action_t             tbl_rdata;
	logic                tbl_we;
	logic [table_aw-1:0] lookup_addr;
	action_t             act;

	logic      out_pkt_evt;
	stat_evt_t evt;

	assign in_data_alf = (data_count >= data_alf_level);
	assign in_md_alf   = (md_count >= md_alf_level);

	// statistics events
	assign evt.in_pkt  = in_data_wr && (in_data.tag == tag_tail);
	assign evt.md_in   = in_md_wr;
	assign evt.out_pkt = out_pkt_evt;

	sync_fifo #(.width(word_w), .depth(data_fifo_depth)) u_data_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (in_data_wr),
		.din   (in_data),
		.rd    (data_pop),
		.dout  (data_head),
		.empty (data_empty),
		.count (data_count)
	);

	sync_fifo #(.width(md_w), .depth(md_fifo_depth)) u_md_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (in_md_wr),
		.din   (in_md),
		.rd    (md_pop),
		.dout  (md_head),
		.empty (md_empty),
		.count (md_count)
	);

	action_table u_action_table (
		.clk     (clk),
		.a_addr  (tbl_addr),
		.a_wdata (tbl_wdata),
		.a_we    (tbl_we),
		.a_rdata (tbl_rdata),
		.b_addr  (lookup_addr),
		.b_rdata (act)
	);

	cfg_slave u_cfg_slave (
		.clk       (clk),
		.rst_n     (rst_n),
		.cfg_req   (cfg_req),
		.cfg       (cfg),
		.cfg_ack   (cfg_ack),
		.cfg_rdata (cfg_rdata),
		.tbl_addr  (tbl_addr),
		.tbl_wdata (tbl_wdata),
		.tbl_we    (tbl_we),
		.tbl_rdata (tbl_rdata),
		.evt       (evt)
	);

	action_engine u_action_engine (
		.clk           (clk),
		.rst_n         (rst_n),
		.sys_max_cpuid (sys_max_cpuid),
		.md_head       (md_head),
		.md_empty      (md_empty),
		.md_pop        (md_pop),
		.data_head     (data_head),
		.data_empty    (data_empty),
		.data_pop      (data_pop),
		.out_alf       (out_alf),
		.lookup_addr   (lookup_addr),
		.act           (act),
		.out_data      (out_data),
		.out_data_wr   (out_data_wr),
		.out_pkt_evt   (out_pkt_evt)
	);

endmodule

/* rtl/action_engine.sv */
// packet scheduler and action execution
// flow lookup, metadata rewrite into the first word, discard, cpu polling
`timescale 1ns/1ps

module action_engine import gac_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [5:0]          sys_max_cpuid,
	input  md_t                 md_head,
	input  logic                md_empty,
	output logic                md_pop,
	input  pkt_word_t           data_head,
	input  logic                data_empty,
	output logic                data_pop,
	input  logic                out_alf,
	output logic [table_aw-1:0] lookup_addr,
	input  action_t             act,
	output pkt_word_t           out_data,
	output logic                out_data_wr,
	output logic                out_pkt_evt
);
	typedef enum logic [2:0] {
		st_idle,
		st_lookup,
		st_wait,
		st_rewrite,
		st_forward,
		st_discard
	} state_e;

	state_e     state;
	logic [5:0] poll_cnt;
	logic [5:0] poll_next;
	logic       start;
	logic       is_local;
	logic       head_tail;
	logic       act_ok;
	md_t        new_md;

	assign start     = !md_empty && !data_empty && !out_alf;
	assign is_local  = (md_head.dmid == local_mid);
	assign head_tail = (data_head.tag == tag_tail);
	assign act_ok    = act.code inside {act_cpu_fixed, act_cpu_poll, act_to_port, act_set_dmid};

	// fifo pops, show-ahead so the head advances next cycle
	assign md_pop   = ((state == st_idle) && start && !is_local) || (state == st_rewrite);
	assign data_pop = ((state == st_forward || state == st_discard) && !data_empty)
	                || ((state == st_rewrite) && act_ok);

	// next polling cpu id, wraps before sys_max_cpuid
	always_comb begin
		if (({1'b0, poll_cnt} + 7'd1) < {1'b0, sys_max_cpuid})
			poll_next = poll_cnt + 6'd1;
		else
			poll_next = '0;
	end

	// ********************
	// metadata rewrite
	// ********************
	always_comb begin
		new_md = md_head;
		case (act.code)
			act_cpu_fixed: begin
				new_md.pktdes  = 1'b1;
				new_md.outtype = 2'd1;
				new_md.outport = act.dmid[5:0];
				new_md.dmid    = next_mid;
			end
			act_cpu_poll: begin
				new_md.pktdes  = 1'b1;
				new_md.outtype = 2'd2;
				new_md.outport = poll_cnt;
				new_md.dmid    = next_mid;
			end
			act_to_port: begin
				new_md.pktdes  = 1'b0;
				new_md.outtype = 2'd0;
				new_md.outport = act.dmid[5:0];
				new_md.dmid    = next_mid;
			end
			act_set_dmid: begin
				new_md.pktdes  = 1'b1;
				new_md.outtype = 2'd0;
				new_md.dmid    = act.dmid;    // outport kept
			end
			default: ;    // packet is dropped anyway
		endcase
	end

	// ********************
	// scheduler FSM
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= st_idle;
			out_data_wr <= 1'b0;
			out_pkt_evt <= 1'b0;
			poll_cnt    <= '0;
		end else begin
			out_data_wr <= 1'b0;
			out_pkt_evt <= 1'b0;
			case (state)
				st_idle: begin
					if (start)
						state <= is_local ? st_lookup : st_forward;
				end
				st_lookup: state <= st_wait;    // table read
				st_wait:   state <= st_rewrite;
				st_rewrite: begin
					if (act_ok) begin
						out_data_wr <= 1'b1;
						out_pkt_evt <= head_tail;
						state       <= head_tail ? st_idle : st_forward;
					end else begin
						state <= st_discard;
					end
					if (act.code == act_cpu_poll)
						poll_cnt <= poll_next;
				end
				st_forward: begin
					// stall without writing while the data fifo runs dry
					if (!data_empty) begin
						out_data_wr <= 1'b1;
						out_pkt_evt <= head_tail;
						if (head_tail)
							state <= st_idle;
					end
				end
				st_discard: begin
					if (!data_empty && head_tail)
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	// lookup address and output word
	always_ff @(posedge clk) begin
		if (state == st_idle)
			lookup_addr <= md_head[flow_idx_msb:flow_idx_lsb];
		if (state == st_rewrite) begin
			out_data.tag  <= data_head.tag;
			out_data.hdr  <= data_head.hdr;
			out_data.body <= new_md;
		end else if (state == st_forward) begin
			out_data <= data_head;
		end
	end

endmodule

/* rtl/cfg_slave.sv */
// register bus slave with four-phase req/ack handshake
// action table access and the three statistics counters
`timescale 1ns/1ps

module cfg_slave import gac_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                cfg_req,
	input  cfg_req_t            cfg,
	output logic                cfg_ack,
	output logic [31:0]         cfg_rdata,
	output logic [table_aw-1:0] tbl_addr,
	output action_t             tbl_wdata,
	output logic                tbl_we,
	input  action_t             tbl_rdata,
	input  stat_evt_t           evt
);
	typedef enum logic [2:0] {
		st_idle,
		st_write,
		st_read,
		st_wait,
		st_ack
	} state_e;

	state_e      state;
	logic [31:0] cnt_in_pkt;
	logic [31:0] cnt_md;
	logic [31:0] cnt_out_pkt;
	logic [31:0] stat_rdata;
	logic        sel_stat;
	logic        capture;

	assign sel_stat = cfg.addr[10];    // 1 = statistics space
	assign capture  = (state == st_ack) && cfg_req && !cfg_ack && cfg.rw;

	// ********************
	// handshake FSM
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			cfg_ack <= 1'b0;
			tbl_we  <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (cfg_req) begin
						if (cfg.rw) begin
							state <= st_read;
						end else begin
							tbl_we <= !sel_stat;    // stat writes are dropped
							state  <= st_write;
						end
					end
				end
				st_write: begin
					tbl_we  <= 1'b0;
					cfg_ack <= 1'b1;
					state   <= st_ack;
				end
				st_read: state <= st_wait;    // RAM samples address
				st_wait: state <= st_ack;
				st_ack: begin
					if (cfg_req) begin
						cfg_ack <= 1'b1;
					end else begin
						cfg_ack <= 1'b0;
						state   <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// address, write data and read capture
	always_ff @(posedge clk) begin
		if (state == st_idle && cfg_req) begin
			tbl_addr  <= cfg.addr[9:2];
			tbl_wdata <= cfg.wdata;
		end
		if (capture)
			cfg_rdata <= sel_stat ? stat_rdata : 32'(tbl_rdata);
	end

	// ********************
	// statistics
	// ********************
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_in_pkt  <= '0;
			cnt_md      <= '0;
			cnt_out_pkt <= '0;
		end else begin
			if (evt.in_pkt)
				cnt_in_pkt <= cnt_in_pkt + 32'd1;
			if (evt.md_in)
				cnt_md <= cnt_md + 32'd1;
			if (evt.out_pkt)
				cnt_out_pkt <= cnt_out_pkt + 32'd1;
		end
	end

	always_comb begin
		case (cfg.addr[9:2])
			stat_in_pkt_idx:  stat_rdata = cnt_in_pkt;
			stat_md_idx:      stat_rdata = cnt_md;
			stat_out_pkt_idx: stat_rdata = cnt_out_pkt;
			default:          stat_rdata = '0;
		endcase
	end

endmodule

/* rtl/action_table.sv */
// dual-port action RAM, 256 x 32
// port A for the register bus, port B for flow lookups
`timescale 1ns/1ps

module action_table import gac_pkg::*; (
	input  logic                clk,
	input  logic [table_aw-1:0] a_addr,
	input  action_t             a_wdata,
	input  logic                a_we,
	output action_t             a_rdata,
	input  logic [table_aw-1:0] b_addr,
	output action_t             b_rdata
);
	action_t mem [0:(1 << table_aw)-1];

	// bus port, read returns the old entry on a write cycle
	always_ff @(posedge clk) begin
		if (a_we)
			mem[a_addr] <= a_wdata;
		a_rdata <= mem[a_addr];
	end

	// lookup port
	always_ff @(posedge clk) begin
		b_rdata <= mem[b_addr];
	end

endmodule

/* rtl/sync_fifo.sv */
// show-ahead synchronous FIFO on a circular buffer
// head word on dout while not empty, fill count for almost-full flags
`timescale 1ns/1ps

module sync_fifo #(
	parameter int width = 8,
	parameter int depth = 16    // power of two
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     wr,
	input  logic [width-1:0]         din,
	input  logic                     rd,
	output logic [width-1:0]         dout,
	output logic                     empty,
	output logic [$clog2(depth):0]   count
);
	localparam int aw = $clog2(depth);

	logic [width-1:0] mem [0:depth-1];
	logic [aw-1:0]    wr_ptr;
	logic [aw-1:0]    rd_ptr;
	logic             full;
	logic             do_wr;
	logic             do_rd;

	assign full  = count[aw];    // count == depth
	assign empty = (count == '0);
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;
	assign dout  = mem[rd_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;    // idle or push and pop together
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= din;
	end

endmodule

/* rtl/gac_pkg.sv */
// shared widths, depths and module ids for the action stage
// action codes, table entry, metadata, packet word and bus records
package gac_pkg;

	// ********************
	// sizes and levels
	// ********************
	localparam int word_w          = 134;
	localparam int tag_w           = 2;
	localparam int md_w            = 128;
	localparam int data_fifo_depth = 256;    // words
	localparam int md_fifo_depth   = 32;     // records
	localparam int data_alf_level  = 192;
	localparam int md_alf_level    = 24;
	localparam int table_aw        = 8;      // 256 entries

	localparam logic [tag_w-1:0] tag_tail = 2'd2;

	localparam logic [7:0] local_mid = 8'd4;
	localparam logic [7:0] next_mid  = 8'd5;

	// statistics register indices, addr[9:2]
	localparam logic [7:0] stat_in_pkt_idx  = 8'd3;
	localparam logic [7:0] stat_md_idx      = 8'd5;
	localparam logic [7:0] stat_out_pkt_idx = 8'd9;

	// flow index position inside the metadata record
	localparam int flow_idx_lsb = 50;
	localparam int flow_idx_msb = 57;

	// ********************
	// types
	// ********************
	typedef enum logic [3:0] {
		act_cpu_fixed = 4'd1,
		act_cpu_poll  = 4'd2,
		act_to_port   = 4'd3,
		act_set_dmid  = 4'd4
	} action_e;    // other codes discard the packet

	typedef struct packed {
		action_e     code;
		logic [19:0] rsvd;
		logic [7:0]  dmid;    // low 6 bits double as outport
	} action_t;

	typedef struct packed {
		logic        pktsrc;
		logic        pktdes;
		logic [5:0]  inport;
		logic [1:0]  outtype;
		logic [5:0]  outport;
		logic [2:0]  prio;       // priority
		logic        discard;
		logic [19:0] misc;
		logic [7:0]  dmid;
		logic [79:0] lower;      // holds the flow index
	} md_t;

	typedef struct packed {
		logic [tag_w-1:0] tag;
		logic [3:0]       hdr;
		logic [md_w-1:0]  body;
	} pkt_word_t;

	typedef struct packed {
		logic        rw;      // 1 = read
		logic [15:0] addr;
		logic [31:0] wdata;
	} cfg_req_t;

	typedef struct packed {
		logic in_pkt;
		logic md_in;
		logic out_pkt;
	} stat_evt_t;

endpackage
